/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := bbox_tb
FILELIST  := bbox.f
BUILD_DIR := obj_dir

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* bbox.f */
+incdir+include
hdl/geom_pkg.sv
hdl/raster_cfg_pkg.sv
hdl/bbox_extent.sv
hdl/bbox_sideband_delay.sv
hdl/bbox_clip.sv
hdl/bbox_top.sv
testbench/bbox_tb.sv

/* hdl/bbox_clip.sv */
module bbox_clip (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    halt_n,
    input  geom_pkg::box_t          ext_box,
    input  logic                    ext_valid,
    input  geom_pkg::tri_item_t     side_item,
    input  raster_cfg_pkg::screen_t screen,
    output geom_pkg::box_t          box,
    output geom_pkg::tri_item_t     tri_out
);
    import geom_pkg::*;

    box_t      clamp_box;
    logic      reject;
    tri_item_t item_d;

    // Clamp lower-left up to the origin, upper-right down to the screen edge
    always_comb begin
        clamp_box = ext_box;
        if (ext_box.ll_x.word < 0) begin
            clamp_box.ll_x.word = '0;
        end
        if (ext_box.ll_y.word < 0) begin
            clamp_box.ll_y.word = '0;
        end
        if (ext_box.ur_x.word > screen.width) begin
            clamp_box.ur_x.word = screen.width;
        end
        if (ext_box.ur_y.word > screen.height) begin
            clamp_box.ur_y.word = screen.height;
        end
    end

    // Box wholly right of, above, left of or below the screen
    // Decided on the floored box before clamping
    assign reject = (ext_box.ll_x.word > screen.width)
                 || (ext_box.ll_y.word > screen.height)
                 || (ext_box.ur_x.word < 0)
                 || (ext_box.ur_y.word < 0);

    // Vertices and color untouched, only valid is rewritten
    always_comb begin
        item_d       = side_item;
        item_d.valid = side_item.valid && !reject;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            box     <= '0;
            tri_out <= '0;
        end else if (halt_n) begin
            box     <= clamp_box;
            tri_out <= item_d;
        end
    end

    // Extent path and sideband delay stay in step
    assert property (@(posedge clk) disable iff (!arst_n)
        ext_valid == side_item.valid);

    // A surviving box sits on screen with its corners in order
    assert property (@(posedge clk) disable iff (!arst_n)
        tri_out.valid |-> (box.ll_x.word >= 0) && (box.ll_y.word >= 0)
                       && (box.ur_x.word <= screen.width)
                       && (box.ur_y.word <= screen.height));
    assert property (@(posedge clk) disable iff (!arst_n)
        tri_out.valid |-> (box.ll_x.word <= box.ur_x.word)
                       && (box.ll_y.word <= box.ur_y.word));

endmodule

/* hdl/bbox_extent.sv */
`include "bbox_cfg.svh"

module bbox_extent (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       halt_n,
    input  geom_pkg::tri_t             tri_in,
    input  logic                       valid_in,
    input  raster_cfg_pkg::subsample_t subsample,
    output geom_pkg::box_t             ext_box,
    output logic                       ext_valid
);
    import geom_pkg::*;

    // Only x and y shape the box, z is skipped
    localparam int unsigned PLANE_AXES = `BBOX_AXES - 1;
    // Fraction bits below the finest sample grid, always cleared
    localparam int unsigned FRAC_LOW = `BBOX_RADIX - `BBOX_SUB_BITS;

    // Vertex coordinates regrouped per axis
    coord_t pts [PLANE_AXES][`BBOX_VERTS];
    // Pairwise less-than: [0] a<b, [1] a<c, [2] b<c
    logic [2:0] cmp [PLANE_AXES];
    // One-hot vertex picks for min and max
    logic [`BBOX_VERTS-1:0] sel_ll [PLANE_AXES];
    logic [`BBOX_VERTS-1:0] sel_ur [PLANE_AXES];
    coord_t lo [PLANE_AXES];
    coord_t hi [PLANE_AXES];
    box_t   box_d;

    // First stage, raw extent
    box_t box_s1;
    logic valid_s1;

    // Grid mask on the fraction field
    logic [`BBOX_SUB_BITS-1:0] keep;
    logic [`BBOX_RADIX-1:0]    frac_mask;
    box_t                      box_fl;

    // Clears fraction bits that lie below the sample grid
    function automatic coord_t floor_coord(coord_t c, logic [`BBOX_RADIX-1:0] m);
        coord_t r;
        r = c;
        r.parts.frac_part = c.parts.frac_part & m;
        return r;
    endfunction

    always_comb begin
        for (int v = 0; v < `BBOX_VERTS; v++) begin
            pts[0][v] = tri_in[v].x;
            pts[1][v] = tri_in[v].y;
        end
    end

    for (genvar a = 0; a < PLANE_AXES; a++) begin : g_axis
        assign cmp[a][0] = pts[a][0].word < pts[a][1].word;
        assign cmp[a][1] = pts[a][0].word < pts[a][2].word;
        assign cmp[a][2] = pts[a][1].word < pts[a][2].word;

        // Ties resolve toward the higher vertex index for min, lower for max
        assign sel_ll[a] = {~cmp[a][1] & ~cmp[a][2],
                            ~cmp[a][0] &  cmp[a][2],
                             cmp[a][0] &  cmp[a][1]};
        assign sel_ur[a] = { cmp[a][1] &  cmp[a][2],
                             cmp[a][0] & ~cmp[a][2],
                            ~cmp[a][0] & ~cmp[a][1]};

        // Exactly one pick per corner and axis
        assert property (@(posedge clk) disable iff (!arst_n) $onehot(sel_ll[a]));
        assert property (@(posedge clk) disable iff (!arst_n) $onehot(sel_ur[a]));
    end

    // AND-OR mux driven by the one-hot picks
    always_comb begin
        for (int a = 0; a < PLANE_AXES; a++) begin
            lo[a] = '0;
            hi[a] = '0;
            for (int v = 0; v < `BBOX_VERTS; v++) begin
                if (sel_ll[a][v]) begin
                    lo[a] = pts[a][v];
                end
                if (sel_ur[a][v]) begin
                    hi[a] = pts[a][v];
                end
            end
        end
    end

    assign box_d = '{ll_x: lo[0], ll_y: lo[1], ur_x: hi[0], ur_y: hi[1]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            box_s1   <= '0;
            valid_s1 <= 1'b0;
        end else if (halt_n) begin
            box_s1   <= box_d;
            valid_s1 <= valid_in;
        end
    end

    // Keep fraction bit i when any grid bit at or below i is set
    for (genvar i = 0; i < `BBOX_SUB_BITS; i++) begin : g_keep
        assign keep[i] = |subsample[i:0];
    end

    assign frac_mask = {keep, {FRAC_LOW{1'b0}}};

    // Floor on the registered extent, second half of the path
    always_comb begin
        box_fl.ll_x = floor_coord(box_s1.ll_x, frac_mask);
        box_fl.ll_y = floor_coord(box_s1.ll_y, frac_mask);
        box_fl.ur_x = floor_coord(box_s1.ur_x, frac_mask);
        box_fl.ur_y = floor_coord(box_s1.ur_y, frac_mask);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ext_box   <= '0;
            ext_valid <= 1'b0;
        end else if (halt_n) begin
            ext_box   <= box_fl;
            ext_valid <= valid_s1;
        end
    end

    // Flooring keeps the order that selection established two stages back
    assert property (@(posedge clk) disable iff (!arst_n)
        ext_valid |-> (ext_box.ll_x.word <= ext_box.ur_x.word));
    assert property (@(posedge clk) disable iff (!arst_n)
        ext_valid |-> (ext_box.ll_y.word <= ext_box.ur_y.word));

endmodule

/* hdl/bbox_sideband_delay.sv */
`include "bbox_cfg.svh"

module bbox_sideband_delay (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 halt_n,
    input  geom_pkg::tri_item_t  item_in,
    output geom_pkg::tri_item_t  item_out
);
    import geom_pkg::*;

    // Same depth as the extent path so the item meets its box in the clip stage
    localparam int unsigned DEPTH = `BBOX_EXT_DEPTH;

    // Index 0 is the youngest entry
    tri_item_t stage_q [DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else if (halt_n) begin
            // Shift only on enabled edges, halt freezes every entry
            stage_q[0] <= item_in;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // Oldest entry
    assign item_out = stage_q[DEPTH-1];

endmodule

/* hdl/bbox_top.sv */
module bbox_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       halt_n,
    input  geom_pkg::tri_item_t        tri_in,
    input  raster_cfg_pkg::screen_t    screen,
    input  raster_cfg_pkg::subsample_t subsample,
    output geom_pkg::tri_item_t        tri_out,
    output geom_pkg::box_t             box
);
    import geom_pkg::*;

    // Floored extent, two enabled stages after the input
    box_t      ext_box;
    logic      ext_valid;
    // Triangle and color on the same schedule
    tri_item_t side_item;

    // Min/max and grid flooring
    bbox_extent u_extent (
        .clk       (clk),
        .arst_n    (arst_n),
        .halt_n    (halt_n),
        .tri_in    (tri_in.verts),
        .valid_in  (tri_in.valid),
        .subsample (subsample),
        .ext_box   (ext_box),
        .ext_valid (ext_valid)
    );

    // Runs beside the extent path
    bbox_sideband_delay u_sideband (
        .clk      (clk),
        .arst_n   (arst_n),
        .halt_n   (halt_n),
        .item_in  (tri_in),
        .item_out (side_item)
    );

    // Joins both paths, third enabled stage
    bbox_clip u_clip (
        .clk       (clk),
        .arst_n    (arst_n),
        .halt_n    (halt_n),
        .ext_box   (ext_box),
        .ext_valid (ext_valid),
        .side_item (side_item),
        .screen    (screen),
        .box       (box),
        .tri_out   (tri_out)
    );

endmodule

/* hdl/geom_pkg.sv */
`include "bbox_cfg.svh"

package geom_pkg;

    // One fixed-point coordinate
    // Compare logic reads the signed word
    // Grid flooring rewrites only the fraction field
    typedef union packed {
        logic signed [`BBOX_SIGFIG-1:0] word;
        struct packed {
            // Integer pixel index, signed
            logic signed [`BBOX_SIGFIG-`BBOX_RADIX-1:0] int_part;
            // Sub-pixel position
            logic [`BBOX_RADIX-1:0] frac_part;
        } parts;
    } coord_t;

    // Vertex in screen space, z rides along untouched
    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    // Vertex a sits at index 0
    typedef vertex_t [`BBOX_VERTS-1:0] tri_t;

    // Unsigned channels, no arithmetic done on them here
    typedef logic [`BBOX_COLORS-1:0][`BBOX_SIGFIG-1:0] color_t;

    // Lower-left and upper-right corners
    typedef struct packed {
        coord_t ll_x;
        coord_t ll_y;
        coord_t ur_x;
        coord_t ur_y;
    } box_t;

    // Triangle as it moves down the raster pipe
    typedef struct packed {
        tri_t   verts;
        color_t color;
        logic   valid;
    } tri_item_t;

endpackage

/* hdl/raster_cfg_pkg.sv */
`include "bbox_cfg.svh"

package raster_cfg_pkg;

    // Sample grid, one-hot
    //   1000  1x, one sample per pixel
    //   0100  4x, half-pixel grid
    //   0010  16x, quarter-pixel grid
    //   0001  64x, eighth-pixel grid
    // Bit i set keeps the top 3-i fraction bits, so the top bit keeps none
    typedef logic [`BBOX_SUB_BITS:0] subsample_t;

    // Screen extent in the coordinate format
    // Lower-left corner of the screen is the origin
    typedef struct packed {
        logic signed [`BBOX_SIGFIG-1:0] width;
        logic signed [`BBOX_SIGFIG-1:0] height;
    } screen_t;

endpackage

/* include/bbox_cfg.svh */
`ifndef BBOX_CFG_SVH
`define BBOX_CFG_SVH

// Fixed-point word width, also used for each color channel
`define BBOX_SIGFIG 24

// Fraction bits in every fixed-point word
`define BBOX_RADIX 10

// Triangle shape
`define BBOX_VERTS 3
// x, y and z per vertex
`define BBOX_AXES 3

// Color channels carried with the triangle
`define BBOX_COLORS 3

// Register stages in the extent path and in the sideband delay
`define BBOX_EXT_DEPTH 2

// Finest sample grid is an eighth of a pixel, three fraction bits
`define BBOX_SUB_BITS 3

`endif

/* testbench/bbox_tb.sv */
`include "bbox_cfg.svh"

module bbox_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import geom_pkg::*;
    import raster_cfg_pkg::*;

    localparam int PERIOD_NS    = 8;
    localparam int RESET_CYCLES = 8;
    localparam int SIG          = `BBOX_SIGFIG;
    localparam int unsigned FRAC_STEPS = 1 << `BBOX_RADIX;
    // 640 by 480 pixel screen
    localparam int SCREEN_W_PX  = 640;
    localparam int SCREEN_H_PX  = 480;
    // Each grid sends 8 on screen, 8 partial, 8 off screen, 4 invalid,
    // 2 around a halt and 24 mixed
    localparam int TRI_PER_GRID = 54;
    localparam int NUM_TRI      = 4 * TRI_PER_GRID;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_TRI * 4 + 100) * PERIOD_NS;

    // Expected outputs for one triangle
    typedef struct packed {
        tri_item_t item;
        box_t      box;
    } expect_t;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       halt_n;
    tri_item_t  tri_in;
    screen_t    screen;
    subsample_t subsample;
    tri_item_t  tri_out;
    box_t       box;

    // Reference pipe, index 0 is the youngest entry
    expect_t exp_q [3];
    expect_t exp_out;

    bbox_top dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .halt_n    (halt_n),
        .tri_in    (tri_in),
        .screen    (screen),
        .subsample (subsample),
        .tri_out   (tri_out),
        .box       (box)
    );

    always #(PERIOD_NS / 2) clk = ~clk;

    function automatic int rand_between(int lo, int hi);
        int unsigned r;
        r = $urandom % unsigned'(hi - lo + 1);
        return lo + int'(r);
    endfunction

    function automatic logic [SIG-1:0] rand_word();
        int unsigned r;
        r = $urandom;
        return r[SIG-1:0];
    endfunction

    // Whole pixel count in the fixed-point format
    function automatic logic [SIG-1:0] px_word(int px);
        int raw;
        raw = px * int'(FRAC_STEPS);
        return raw[SIG-1:0];
    endfunction

    // Random pixel in [lo_px, hi_px] plus a random fraction
    function automatic coord_t rand_coord(int lo_px, int hi_px);
        coord_t c;
        int     raw;
        raw = rand_between(lo_px, hi_px) * int'(FRAC_STEPS) + int'($urandom % FRAC_STEPS);
        c.word = raw[SIG-1:0];
        return c;
    endfunction

    // Fraction bits that each grid keeps
    function automatic int grid_frac_bits(subsample_t sub);
        case (sub)
            4'b0100: return 1;
            4'b0010: return 2;
            4'b0001: return 3;
            default: return 0;
        endcase
    endfunction

    // Expected box and item straight from the bounding-box rules
    function automatic expect_t predict(tri_item_t it, subsample_t sub, screen_t scr);
        expect_t               e;
        logic signed [SIG-1:0] lo_x;
        logic signed [SIG-1:0] lo_y;
        logic signed [SIG-1:0] hi_x;
        logic signed [SIG-1:0] hi_y;
        logic [SIG-1:0]        mask;
        logic                  reject;
        lo_x = it.verts[0].x.word;
        hi_x = lo_x;
        lo_y = it.verts[0].y.word;
        hi_y = lo_y;
        for (int v = 1; v < `BBOX_VERTS; v++) begin
            lo_x = (it.verts[v].x.word < lo_x) ? it.verts[v].x.word : lo_x;
            hi_x = (it.verts[v].x.word > hi_x) ? it.verts[v].x.word : hi_x;
            lo_y = (it.verts[v].y.word < lo_y) ? it.verts[v].y.word : lo_y;
            hi_y = (it.verts[v].y.word > hi_y) ? it.verts[v].y.word : hi_y;
        end
        // Floor toward minus infinity on the sample grid
        mask = '1;
        mask = mask << (`BBOX_RADIX - grid_frac_bits(sub));
        lo_x = lo_x & mask;
        lo_y = lo_y & mask;
        hi_x = hi_x & mask;
        hi_y = hi_y & mask;
        // Off screen test on the floored box, before clamping
        reject = (lo_x > scr.width) || (lo_y > scr.height) || (hi_x < 0) || (hi_y < 0);
        e.item = it;
        e.item.valid = it.valid && !reject;
        e.box.ll_x.word = (lo_x < 0) ? '0 : lo_x;
        e.box.ll_y.word = (lo_y < 0) ? '0 : lo_y;
        e.box.ur_x.word = (hi_x > scr.width) ? scr.width : hi_x;
        e.box.ur_y.word = (hi_y > scr.height) ? scr.height : hi_y;
        return e;
    endfunction

    function automatic tri_item_t make_tri(int x_lo, int x_hi, int y_lo, int y_hi,
                                           logic valid);
        tri_item_t t;
        for (int v = 0; v < `BBOX_VERTS; v++) begin
            t.verts[v].x = rand_coord(x_lo, x_hi);
            t.verts[v].y = rand_coord(y_lo, y_hi);
            t.verts[v].z.word = rand_word();
        end
        for (int c = 0; c < `BBOX_COLORS; c++) begin
            t.color[c] = rand_word();
        end
        t.valid = valid;
        return t;
    endfunction

    function automatic tri_item_t onscreen_tri(logic valid);
        return make_tri(0, SCREEN_W_PX - 1, 0, SCREEN_H_PX - 1, valid);
    endfunction

    // Vertex 0 on screen while the other two may reach past any edge
    function automatic tri_item_t partial_tri();
        tri_item_t t;
        t = make_tri(-300, 900, -300, 700, 1'b1);
        t.verts[0].x = rand_coord(0, SCREEN_W_PX - 1);
        t.verts[0].y = rand_coord(0, SCREEN_H_PX - 1);
        return t;
    endfunction

    // Side 0 left, 1 right, 2 below, 3 above
    function automatic tri_item_t offscreen_tri(int side);
        case (side)
            0: return make_tri(-400, -1, -300, 700, 1'b1);
            1: return make_tri(SCREEN_W_PX + 1, 1000, -300, 700, 1'b1);
            2: return make_tri(-300, 900, -400, -1, 1'b1);
            default: return make_tri(-300, 900, SCREEN_H_PX + 1, 800, 1'b1);
        endcase
    endfunction

    // Model advances only on enabled edges like the DUT
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 3; i++) begin
                exp_q[i] <= '0;
            end
        end else if (halt_n) begin
            exp_q[0] <= predict(tri_in, subsample, screen);
            exp_q[1] <= exp_q[0];
            exp_q[2] <= exp_q[1];
        end
    end

    assign exp_out = exp_q[2];

    task automatic flag_mismatch(string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "output check failed");
    endtask

    assert property (@(posedge clk) !arst_n |=> !tri_out.valid)
        else flag_mismatch("tri_out.valid high right after reset");

    assert property (@(posedge clk) disable iff (!arst_n)
        tri_out.valid == exp_out.item.valid)
        else flag_mismatch($sformatf("tri_out.valid is %b, expected %b",
            $sampled(tri_out.valid), $sampled(exp_out.item.valid)));

    assert property (@(posedge clk) disable iff (!arst_n) box == exp_out.box)
        else flag_mismatch($sformatf("box is %h, expected %h",
            $sampled(box), $sampled(exp_out.box)));

    // Vertices, z included, and color pass through untouched
    assert property (@(posedge clk) disable iff (!arst_n)
        (tri_out.verts == exp_out.item.verts) && (tri_out.color == exp_out.item.color))
        else flag_mismatch($sformatf("triangle or color is %h, expected %h",
            $sampled(tri_out), $sampled(exp_out.item)));

    // Halt freezes the outputs
    assert property (@(posedge clk) disable iff (!arst_n)
        !halt_n |=> $stable(box) && $stable(tri_out))
        else flag_mismatch("outputs changed while halt_n was low");

    task automatic send(tri_item_t item);
        @(posedge clk);
        tri_in <= item;
        halt_n <= 1'b1;
    endtask

    // Valid triangles wait at the input and must be dropped
    task automatic stall(int cycles);
        repeat (cycles) begin
            @(posedge clk);
            tri_in <= onscreen_tri(1'b1);
            halt_n <= 1'b0;
        end
    endtask

    // Zero triangles flush the pipe since zero lies on every grid
    task automatic drain();
        repeat (3) send('0);
    endtask

    task automatic set_grid(subsample_t grid);
        drain();
        @(posedge clk);
        subsample <= grid;
        tri_in    <= '0;
        halt_n    <= 1'b1;
    endtask

    task automatic run_grid_tests();
        int kind;
        repeat (8) send(onscreen_tri(1'b1));
        repeat (8) send(partial_tri());
        for (int s = 0; s < 8; s++) begin
            send(offscreen_tri(s % 4));
        end
        repeat (4) send(onscreen_tri(1'b0));
        send(onscreen_tri(1'b1));
        stall(5);
        send(onscreen_tri(1'b1));
        // Mixed stream with random halts
        repeat (24) begin
            if ($urandom % 4 == 0) begin
                stall(1 + int'($urandom % 3));
            end
            kind = int'($urandom % 4);
            case (kind)
                0: send(onscreen_tri(1'b1));
                1: send(partial_tri());
                2: send(offscreen_tri(int'($urandom % 4)));
                default: send(onscreen_tri(($urandom % 2) == 1));
            endcase
        end
    endtask

    initial begin
        void'($urandom(32'h5ced_168e));
        arst_n        = 1'b0;
        halt_n        = 1'b1;
        tri_in        = '0;
        subsample     = 4'b1000;
        screen.width  = px_word(SCREEN_W_PX);
        screen.height = px_word(SCREEN_H_PX);
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        // 1x, 4x, 16x, 64x
        for (int g = 0; g < 4; g++) begin
            set_grid(subsample_t'(4'b1000 >> g));
            run_grid_tests();
        end
        drain();
        repeat (2) @(posedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the triangle stream did not finish in the expected time");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule
